/* hdl/matmul_macros.svh */
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// array and datapath sizes
////////////////////////////////////////////////////////////////////////////

`define MM_N 4
`define MM_ELEM_W 16

// wishbone word address and data widths
`define MM_WB_ADR_W 6
`define MM_WB_DAT_W 32

////////////////////////////////////////////////////////////////////////////
// register map, word addresses
////////////////////////////////////////////////////////////////////////////

`define MM_A_BASE 6'h00
`define MM_B_BASE 6'h10
`define MM_C_BASE 6'h20
`define MM_CTRL_ADDR 6'h30

// skew steps for all anti-diagonals plus the pipeline tail
`define MM_RUN_CYCLES (3 * `MM_N - 2 + 3)

`endif

/* hdl/matmul_pkg.sv */
`default_nettype none

`include "matmul_macros.svh"

package matmul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // element and aggregate types
  ////////////////////////////////////////////////////////////////////////////

  // one signed matrix element
  typedef logic signed [`MM_ELEM_W-1:0] elem_t;

  // one lane per row or column of the array
  typedef elem_t [`MM_N-1:0] vec_t;

  // indexed [row][col]
  typedef vec_t [`MM_N-1:0] mat_t;

  ////////////////////////////////////////////////////////////////////////////
  // counters and indices
  ////////////////////////////////////////////////////////////////////////////

  // row, column or vector number
  typedef logic [$clog2(`MM_N)-1:0] idx_t;

  // run step, wide enough for the whole busy window
  typedef logic [$clog2(`MM_RUN_CYCLES)-1:0] step_t;

endpackage

`default_nettype wire

/* hdl/bank_wr_if.sv */
`default_nettype none

// host write port of one operand bank
interface bank_wr_if;

  // one-cycle write strobe
  logic we;

  // which stored vector, k for both banks
  matmul_pkg::idx_t vec_idx;

  // lane within that vector, row of A or column of B
  matmul_pkg::idx_t lane;

  matmul_pkg::elem_t data;

  // control block side
  modport ctrl (
    output we,
    output vec_idx,
    output lane,
    output data
  );

  // operand bank side
  modport bank (
    input we,
    input vec_idx,
    input lane,
    input data
  );

endinterface

`default_nettype wire

/* hdl/processing_element.sv */
`default_nettype none

`include "matmul_macros.svh"

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::elem_t in_a,
  input  matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t out_a,
  output matmul_pkg::elem_t out_b,
  output matmul_pkg::elem_t acc
);

  // full signed product, only the low half is kept
  logic signed [2*`MM_ELEM_W-1:0] prod_full;

  assign prod_full = in_a * in_b;

  // pass operands on to the right and down
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // wrapping accumulate, idle cycles add zero
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else begin
      acc <= acc + prod_full[`MM_ELEM_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* hdl/pe_array.sv */
`default_nettype none

`include "matmul_macros.svh"

module pe_array (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  matmul_pkg::vec_t a_lanes,
  input  matmul_pkg::vec_t b_lanes,
  output matmul_pkg::mat_t result
);

  ////////////////////////////////////////////////////////////////////////////
  // operand mesh
  ////////////////////////////////////////////////////////////////////////////

  // a_h[i][j] enters cell (i,j) from the left
  matmul_pkg::elem_t a_h [`MM_N][`MM_N+1];

  // b_v[i][j] enters cell (i,j) from above
  matmul_pkg::elem_t b_v [`MM_N+1][`MM_N];

  // left edge is fed by the A bank
  for (genvar i = 0; i < `MM_N; i++) begin : g_left
    assign a_h[i][0] = a_lanes[i];
  end

  // top edge is fed by the B bank
  for (genvar j = 0; j < `MM_N; j++) begin : g_top
    assign b_v[0][j] = b_lanes[j];
  end

  ////////////////////////////////////////////////////////////////////////////
  // cell grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `MM_N; i++) begin : g_row
    for (genvar j = 0; j < `MM_N; j++) begin : g_col
      // cell (i,j) builds C[i][j]
      processing_element pe_i (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_h[i][j]),
        .in_b  (b_v[i][j]),
        .out_a (a_h[i][j+1]),
        .out_b (b_v[i+1][j]),
        .acc   (result[i][j])
      );
    end
  end

endmodule

`default_nettype wire

/* hdl/operand_bank.sv */
`default_nettype none

`include "matmul_macros.svh"

module operand_bank (
  input  logic               clk,
  input  logic               reset,
  bank_wr_if.bank            wr,
  input  logic               run,
  input  matmul_pkg::step_t  step,
  output matmul_pkg::vec_t   lanes
);

  // storage, indexed [vector][lane]
  matmul_pkg::elem_t store [`MM_N][`MM_N];

  matmul_pkg::vec_t lanes_next;

  ////////////////////////////////////////////////////////////////////////////
  // host writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr.we) begin
      store[wr.vec_idx][wr.lane] <= wr.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // skewed stream
  ////////////////////////////////////////////////////////////////////////////

  // lane m runs m steps behind lane 0, zero outside its window
  always_comb begin
    logic [$bits(matmul_pkg::step_t):0] offs;
    offs = '0;
    for (int m = 0; m < `MM_N; m++) begin
      lanes_next[m] = '0;
      offs = {1'b0, step} - ($bits(offs))'(m);
      if (run && ({1'b0, step} >= ($bits(offs))'(m)) &&
          (offs < ($bits(offs))'(`MM_N))) begin
        lanes_next[m] = store[matmul_pkg::idx_t'(offs)][m];
      end
    end
  end

  // registered, so the array sees step t one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      lanes <= '0;
    end else begin
      lanes <= lanes_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/matmul_wb_ctrl.sv */
`default_nettype none

`include "matmul_macros.svh"

module matmul_wb_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`MM_WB_ADR_W-1:0] wb_adr,
  input  logic [`MM_WB_DAT_W-1:0] wb_dat_w,
  output logic [`MM_WB_DAT_W-1:0] wb_dat_r,
  output logic                    wb_ack,
  bank_wr_if.ctrl                 a_wr,
  bank_wr_if.ctrl                 b_wr,
  output logic                    run,
  output matmul_pkg::step_t       step,
  output logic                    clear,
  input  matmul_pkg::mat_t        result
);

  // index bits per row or column field
  localparam int IW = $clog2(`MM_N);

  localparam matmul_pkg::step_t STEP_LAST = matmul_pkg::step_t'(`MM_RUN_CYCLES - 1);

  logic req;
  logic wr_req;
  logic hit_a;
  logic hit_b;
  logic hit_c;
  logic hit_ctrl;
  logic start;
  logic done;

  matmul_pkg::idx_t hi_idx;
  matmul_pkg::idx_t lo_idx;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // new request only, the ack cycle itself is not taken again
  assign req    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_req = req & wb_we;

  // regions are MM_N*MM_N words apart
  assign hit_a    = wb_adr[`MM_WB_ADR_W-1:2*IW] == (`MM_A_BASE >> (2 * IW));
  assign hit_b    = wb_adr[`MM_WB_ADR_W-1:2*IW] == (`MM_B_BASE >> (2 * IW));
  assign hit_c    = wb_adr[`MM_WB_ADR_W-1:2*IW] == (`MM_C_BASE >> (2 * IW));
  assign hit_ctrl = wb_adr == `MM_CTRL_ADDR;

  // element index is hi*N+lo
  assign hi_idx = wb_adr[2*IW-1:IW];
  assign lo_idx = wb_adr[IW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // bank writes, dropped while busy
  ////////////////////////////////////////////////////////////////////////////

  // A is stored by column k, lane is the row
  assign a_wr.we      = wr_req & hit_a & ~run;
  assign a_wr.vec_idx = lo_idx;
  assign a_wr.lane    = hi_idx;
  assign a_wr.data    = wb_dat_w[`MM_ELEM_W-1:0];

  // B is stored by row k, lane is the column
  assign b_wr.we      = wr_req & hit_b & ~run;
  assign b_wr.vec_idx = hi_idx;
  assign b_wr.lane    = lo_idx;
  assign b_wr.data    = wb_dat_w[`MM_ELEM_W-1:0];

  assign start = wr_req & hit_ctrl & wb_dat_w[0] & ~run;

  ////////////////////////////////////////////////////////////////////////////
  // ack and run sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      run   <= 1'b0;
      step  <= '0;
      clear <= 1'b0;
      done  <= 1'b0;
    end else begin
      // accumulators wiped during step 0
      clear <= start;
      if (start) begin
        run  <= 1'b1;
        step <= '0;
        done <= 1'b0;
      end else if (run) begin
        if (step == STEP_LAST) begin
          run  <= 1'b0;
          done <= 1'b1;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////////////////////

  // valid in the ack cycle, zero for A, B and unmapped words
  always_ff @(posedge clk) begin
    wb_dat_r <= '0;
    if (req && !wb_we) begin
      if (hit_c) begin
        wb_dat_r[`MM_ELEM_W-1:0] <= result[hi_idx][lo_idx];
      end else if (hit_ctrl) begin
        wb_dat_r[1:0] <= {done, run};
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/matmul_wb_top.sv */
`default_nettype none

`include "matmul_macros.svh"

module matmul_wb_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`MM_WB_ADR_W-1:0] wb_adr,
  input  logic [`MM_WB_DAT_W-1:0] wb_dat_w,
  output logic [`MM_WB_DAT_W-1:0] wb_dat_r,
  output logic                    wb_ack
);

  // host write paths into the two banks
  bank_wr_if a_wr ();
  bank_wr_if b_wr ();

  logic              run;
  logic              clear;
  matmul_pkg::step_t step;
  matmul_pkg::vec_t  a_lanes;
  matmul_pkg::vec_t  b_lanes;
  matmul_pkg::mat_t  result;

  ////////////////////////////////////////////////////////////////////////////
  // host interface and sequencing
  ////////////////////////////////////////////////////////////////////////////

  matmul_wb_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .a_wr     (a_wr.ctrl),
    .b_wr     (b_wr.ctrl),
    .run      (run),
    .step     (step),
    .clear    (clear),
    .result   (result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // operand banks, both stream side by side
  ////////////////////////////////////////////////////////////////////////////

  operand_bank a_bank_i (
    .clk   (clk),
    .reset (reset),
    .wr    (a_wr.bank),
    .run   (run),
    .step  (step),
    .lanes (a_lanes)
  );

  operand_bank b_bank_i (
    .clk   (clk),
    .reset (reset),
    .wr    (b_wr.bank),
    .run   (run),
    .step  (step),
    .lanes (b_lanes)
  );

  // systolic grid
  pe_array array_i (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .result  (result)
  );

endmodule

`default_nettype wire

/* bench/tb_matmul_util.svh */
`ifndef TB_MATMUL_UTIL_SVH
`define TB_MATMUL_UTIL_SVH

////////////////////////////////////////////////////////////////////////////
// random data
////////////////////////////////////////////////////////////////////////////

function automatic matmul_pkg::elem_t rand_elem();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return matmul_pkg::elem_t'(lcg_state[31:16]);
endfunction

function automatic matmul_pkg::mat_t rand_mat();
  matmul_pkg::mat_t m;
  for (int i = 0; i < `MM_N; i++) begin
    for (int j = 0; j < `MM_N; j++) begin
      m[i][j] = rand_elem();
    end
  end
  return m;
endfunction

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////

// plain triple loop, sums wrap at 16 bits
function automatic matmul_pkg::mat_t mat_product(input matmul_pkg::mat_t a,
                                                 input matmul_pkg::mat_t b);
  matmul_pkg::mat_t c;
  logic signed [2*`MM_ELEM_W-1:0] p;
  for (int i = 0; i < `MM_N; i++) begin
    for (int j = 0; j < `MM_N; j++) begin
      c[i][j] = '0;
      for (int k = 0; k < `MM_N; k++) begin
        p = a[i][k] * b[k][j];
        c[i][j] = c[i][j] + p[`MM_ELEM_W-1:0];
      end
    end
  end
  return c;
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_elem(input string name, input matmul_pkg::elem_t expected,
                          input matmul_pkg::elem_t actual);
  if (actual !== expected) begin
    value_errs++;
    $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
  end
endtask

// status word, bit0 busy and bit1 done
task automatic check_status(input string name, input logic exp_busy, input logic exp_done,
                            input logic [`MM_WB_DAT_W-1:0] word);
  if (word[1:0] !== {exp_done, exp_busy}) begin
    value_errs++;
    $display("[FAIL] %s expected busy %0b done %0b actual busy %0b done %0b",
             name, exp_busy, exp_done, word[0], word[1]);
  end
endtask

`endif

/* bench/tb_matmul.sv */
`default_nettype none

`include "matmul_macros.svh"

module tb_matmul;

  // 6 runs of 32 writes, 16 reads and 64 polls, about 3 cycles each
  localparam int CYCLE_LIMIT = 6 * (32 + 16 + 64) * 3 + 200;

  logic                    clk;
  logic                    reset;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [`MM_WB_ADR_W-1:0] wb_adr;
  logic [`MM_WB_DAT_W-1:0] wb_dat_w;
  logic [`MM_WB_DAT_W-1:0] wb_dat_r;
  logic                    wb_ack;

  int          value_errs;
  int          proto_errs;
  int          cycles;
  logic [31:0] lcg_state;

  // handoff to the checker process
  logic             cmp_req;
  string            cmp_name;
  matmul_pkg::mat_t exp_m;
  matmul_pkg::mat_t got;

  matmul_pkg::mat_t a_m;
  matmul_pkg::mat_t b_m;

  `include "tb_matmul_util.svh"

  matmul_wb_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: simulation still running after %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // compares a read-back C against the expected matrix
  always @(posedge clk) begin
    if (cmp_req) begin
      for (int i = 0; i < `MM_N; i++) begin
        for (int j = 0; j < `MM_N; j++) begin
          check_elem($sformatf("%s c[%0d][%0d]", cmp_name, i, j), exp_m[i][j], got[i][j]);
        end
      end
      cmp_req = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // wishbone master, inputs change on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [`MM_WB_ADR_W-1:0] adr,
                           input logic [`MM_WB_DAT_W-1:0] wdat,
                           output logic [`MM_WB_DAT_W-1:0] rdat);
    int waits;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waits    = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_ack && waits < 8);
    rdat = wb_dat_r;
    if (!wb_ack) begin
      proto_errs++;
      $display("no ack within 8 cycles for access to word 0x%h", adr);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [`MM_WB_ADR_W-1:0] adr,
                          input logic [`MM_WB_DAT_W-1:0] dat);
    logic [`MM_WB_DAT_W-1:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [`MM_WB_ADR_W-1:0] adr,
                         output logic [`MM_WB_DAT_W-1:0] dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run steps
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_operands();
    logic [`MM_WB_ADR_W-1:0] idx;
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        idx = `MM_WB_ADR_W'(i * `MM_N + j);
        wb_write(`MM_A_BASE + idx, {16'h0, a_m[i][j]});
        wb_write(`MM_B_BASE + idx, {16'h0, b_m[i][j]});
      end
    end
  endtask

  task automatic wait_done(input string name);
    logic [`MM_WB_DAT_W-1:0] st;
    int polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < 64) begin
      wb_read(`MM_CTRL_ADDR, st);
      polls++;
    end
    if (st[1]) begin
      check_status(name, 1'b0, 1'b1, st);
    end else begin
      proto_errs++;
      $display("%s: done never set within 64 status polls", name);
    end
  endtask

  task automatic read_and_compare(input string name);
    logic [`MM_WB_DAT_W-1:0] d;
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        wb_read(`MM_C_BASE + `MM_WB_ADR_W'(i * `MM_N + j), d);
        got[i][j] = d[`MM_ELEM_W-1:0];
      end
    end
    cmp_name = name;
    cmp_req  = 1'b1;
    wait (!cmp_req);
  endtask

  initial begin
    logic [`MM_WB_DAT_W-1:0] d;
    clk        = 1'b0;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    value_errs = 0;
    proto_errs = 0;
    cycles     = 0;
    lcg_state  = 32'hec4e;
    cmp_req    = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // idle state out of reset
    wb_read(`MM_CTRL_ADDR, d);
    check_status("reset status", 1'b0, 1'b0, d);
    exp_m = '0;
    read_and_compare("reset");

    // identity times B is B
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        a_m[i][j] = (i == j) ? 16'sd1 : 16'sd0;
      end
    end
    b_m = rand_mat();
    load_operands();
    wb_write(`MM_CTRL_ADDR, 32'h1);
    wait_done("identity");
    exp_m = b_m;
    read_and_compare("identity");

    // full range values, sums overflow
    for (int r = 0; r < 3; r++) begin
      a_m = rand_mat();
      b_m = rand_mat();
      load_operands();
      wb_write(`MM_CTRL_ADDR, 32'h1);
      wait_done($sformatf("random %0d", r));
      exp_m = mat_product(a_m, b_m);
      read_and_compare($sformatf("random %0d", r));
    end

    // done stays set until the next start
    a_m = rand_mat();
    b_m = rand_mat();
    load_operands();
    wb_read(`MM_CTRL_ADDR, d);
    check_status("sticky done", 1'b0, 1'b1, d);
    wb_write(`MM_CTRL_ADDR, 32'h1);
    wb_read(`MM_CTRL_ADDR, d);
    check_status("restart busy", 1'b1, 1'b0, d);
    wait_done("back to back");
    exp_m = mat_product(a_m, b_m);
    read_and_compare("back to back");

    // operand writes during the run must not land
    a_m = rand_mat();
    b_m = rand_mat();
    load_operands();
    exp_m = mat_product(a_m, b_m);
    wb_write(`MM_CTRL_ADDR, 32'h1);
    // late words of both banks, still ahead of the stream when written
    for (int n = 0; n < 2; n++) begin
      wb_write(`MM_A_BASE + `MM_WB_ADR_W'(`MM_N * `MM_N - 2 + n), {16'h0, rand_elem()});
      wb_write(`MM_B_BASE + `MM_WB_ADR_W'(`MM_N * `MM_N - 2 + n), {16'h0, rand_elem()});
    end
    wait_done("busy writes");
    for (int n = 0; n < `MM_N; n++) begin
      wb_write(`MM_C_BASE + `MM_WB_ADR_W'(5 * n), 32'h0000_7fff);
      wb_read(`MM_A_BASE + `MM_WB_ADR_W'(n), d);
      check_elem($sformatf("a read %0d", n), '0, d[`MM_ELEM_W-1:0]);
    end
    read_and_compare("busy writes");

    $display("errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
+incdir+bench
hdl/matmul_pkg.sv
hdl/bank_wr_if.sv
hdl/processing_element.sv
hdl/pe_array.sv
hdl/operand_bank.sv
hdl/matmul_wb_ctrl.sv
hdl/matmul_wb_top.sv
bench/tb_matmul.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matmul testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_matmul \
  -f filelist.f \
  -o tb_matmul

./obj_dir/tb_matmul > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0
